/* hw/cpu_req_pkg.sv */
`default_nettype none

package cpu_req_pkg;

    localparam int ADDR_W   = 32;
    localparam int WORD_W   = 32;
    localparam int STRB_W   = 4;    // bytes per word

    // address split as seen by the pipeline
    localparam int TAG_W    = 20;   // addr[31:12]
    localparam int INDEX_W  = 8;    // addr[11:4]
    localparam int OFFSET_W = 4;    // addr[3:0]

    // word lane inside a 16-byte line
    localparam int LANE_LSB = 2;
    localparam int LANE_W   = 2;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [STRB_W-1:0]   wstrb_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    // access type codes shared by the pipeline and the bus
    typedef enum logic [2:0] {
        size_byte = 3'b000,
        size_half = 3'b001,
        size_word = 3'b010,
        size_line = 3'b100
    } access_size_e;

endpackage

`default_nettype wire

/* hw/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

    localparam int LINE_W      = 128;
    localparam int LINE_STRB_W = 16;    // one bit per line byte
    localparam int LINE_OFF_W  = 4;     // byte offset bits inside a line

    // backing RAM geometry, 1 KB in total
    localparam int RAM_LINES   = 64;
    localparam int RAM_IDX_W   = 6;     // addr[9:4]

    localparam int CFG_DATA_W  = 32;

    typedef logic [LINE_W-1:0]      line_t;
    typedef logic [LINE_STRB_W-1:0] line_strb_t;
    typedef logic [CFG_DATA_W-1:0]  cfg_data_t;

    // config register map
    typedef enum logic [1:0] {
        reg_win_base     = 2'd0,
        reg_win_mask     = 2'd1,
        reg_fill_count   = 2'd2,
        reg_narrow_count = 2'd3
    } cfg_addr_e;

endpackage

`default_nettype wire

/* hw/passthru_dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module passthru_dcache
    import cpu_req_pkg::*, mem_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    // pipeline side
    input  logic         valid,
    input  logic         op,        // 1 store, 0 load
    input  logic         uncache,
    input  index_t       index,
    input  tag_t         tag,
    input  offset_t      offset,
    input  wstrb_t       wstrb,
    input  word_t        wdata,
    input  access_size_e size,
    output logic         addr_ok,
    output logic         data_ok,
    output word_t        rdata,

    // memory bus side
    output logic         rd_req,
    output access_size_e rd_type,
    output addr_t        rd_addr,
    input  logic         rd_rdy,
    input  logic         ret_valid,
    input  logic         ret_last,
    input  line_t        ret_data,
    output logic         wr_req,
    output addr_t        wr_addr,
    output line_strb_t   wr_wstrb,
    output line_t        wr_data,
    input  logic         wr_rdy
);

    typedef enum logic [2:0] {
        IDLE,
        LOOK_UP,
        READ_REQ,
        READ_WAIT,
        WRITE_REQ
    } state_e;

    state_e state;
    state_e next_state;

    // request buffer, loaded when a request is taken
    logic         op_buf;
    logic         uncache_buf;
    tag_t         tag_buf;
    index_t       index_buf;
    offset_t      offset_buf;
    wstrb_t       wstrb_buf;
    word_t        wdata_buf;
    access_size_e size_buf;

    addr_t             req_addr;
    logic [LANE_W-1:0] lane;
    logic              take;
    logic              done;

    assign take = (state == IDLE) && valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (valid) begin
                    next_state = LOOK_UP;
                end
            end
            LOOK_UP: begin
                next_state = op_buf ? WRITE_REQ : READ_REQ;
            end
            READ_REQ: begin
                if (rd_rdy) begin
                    next_state = READ_WAIT;     // read accepted this cycle
                end
            end
            READ_WAIT: begin
                if (ret_valid && ret_last) begin
                    next_state = IDLE;
                end
            end
            WRITE_REQ: begin
                if (wr_rdy) begin
                    next_state = IDLE;          // single beat, done on accept
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (take) begin
            op_buf      <= op;
            uncache_buf <= uncache;
            tag_buf     <= tag;
            index_buf   <= index;
            offset_buf  <= offset;
            wstrb_buf   <= wstrb;
            wdata_buf   <= wdata;
            size_buf    <= size;
        end
    end

    assign req_addr = {tag_buf, index_buf, offset_buf};
    assign lane     = req_addr[LANE_LSB +: LANE_W];

    // read channel, line fill unless the window says uncached
    assign rd_req  = (state == READ_REQ);
    assign rd_type = uncache_buf ? size_buf : size_line;
    assign rd_addr = uncache_buf ? req_addr : {tag_buf, index_buf, {OFFSET_W{1'b0}}};

    // write channel, word placed in its lane of the line
    assign wr_req   = (state == WRITE_REQ);
    assign wr_addr  = req_addr;
    assign wr_wstrb = line_strb_t'(wstrb_buf) << (lane * STRB_W);
    assign wr_data  = line_t'(wdata_buf) << (lane * WORD_W);

    // both handshakes complete in the same cycle
    assign done = ((state == READ_WAIT) && ret_valid && ret_last)
                || ((state == WRITE_REQ) && wr_rdy);

    assign addr_ok = done;
    assign data_ok = done;
    assign rdata   = ret_data[lane * WORD_W +: WORD_W];    // whole word, no narrowing

endmodule

`default_nettype wire

/* hw/uncache_window_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module uncache_window_regs
    import cpu_req_pkg::*, mem_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  tag_t         tag,
    output logic         uncache,

    // config port
    input  logic         cfg_valid,
    output logic         cfg_ready,
    input  logic         cfg_write,
    input  cfg_addr_e    cfg_addr,
    input  cfg_data_t    cfg_wdata,
    output logic         cfg_rvalid,
    output cfg_data_t    cfg_rdata,

    // snooped bus read handshake
    input  logic         rd_req,
    input  logic         rd_rdy,
    input  access_size_e rd_type
);

    cfg_data_t win_base;
    cfg_data_t win_mask;
    cfg_data_t fill_count;
    cfg_data_t narrow_count;

    logic cfg_wr;
    logic cfg_rd;
    logic rd_fire;

    assign cfg_ready = 1'b1;
    assign cfg_wr    = cfg_valid && cfg_ready && cfg_write;
    assign cfg_rd    = cfg_valid && cfg_ready && !cfg_write;
    assign rd_fire   = rd_req && rd_rdy;

    // mask of zero puts every tag in the window
    assign uncache = (tag & win_mask[TAG_W-1:0]) == (win_base[TAG_W-1:0] & win_mask[TAG_W-1:0]);

    always_ff @(posedge clk) begin
        if (rst) begin
            win_base <= '0;
            win_mask <= '0;
        end else if (cfg_wr) begin
            if (cfg_addr == reg_win_base) begin
                win_base <= cfg_wdata;
            end
            if (cfg_addr == reg_win_mask) begin
                win_mask <= cfg_wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_count   <= '0;
            narrow_count <= '0;
        end else begin
            if (cfg_wr && (cfg_addr == reg_fill_count)) begin
                fill_count <= '0;                       // clear wins over a fill
            end else if (rd_fire && (rd_type == size_line)) begin
                fill_count <= fill_count + 32'd1;
            end
            if (cfg_wr && (cfg_addr == reg_narrow_count)) begin
                narrow_count <= '0;
            end else if (rd_fire && (rd_type != size_line)) begin
                narrow_count <= narrow_count + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_rvalid <= 1'b0;
        end else begin
            cfg_rvalid <= cfg_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_rd) begin
            case (cfg_addr)
                reg_win_base:     cfg_rdata <= win_base;
                reg_win_mask:     cfg_rdata <= win_mask;
                reg_fill_count:   cfg_rdata <= fill_count;
                reg_narrow_count: cfg_rdata <= narrow_count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/line_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module line_ram
    import cpu_req_pkg::*, mem_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // read channel
    input  logic       rd_req,
    input  addr_t      rd_addr,
    output logic       rd_rdy,
    output logic       ret_valid,
    output logic       ret_last,
    output line_t      ret_data,

    // write channel
    input  logic       wr_req,
    input  addr_t      wr_addr,
    input  line_strb_t wr_wstrb,
    input  line_t      wr_data,
    output logic       wr_rdy
);

    line_t mem [RAM_LINES];

    logic [RAM_IDX_W-1:0] rd_idx;
    logic [RAM_IDX_W-1:0] wr_idx;

    // acceptance pacing
    logic [1:0] free_cnt;       // wraps every 4 cycles
    logic [1:0] wait_cnt;
    logic       pending;        // request seen but still stalled
    logic       ready;
    logic       any_req;
    logic       rd_fire;
    logic       wr_fire;

    assign rd_idx = rd_addr[LINE_OFF_W +: RAM_IDX_W];
    assign wr_idx = wr_addr[LINE_OFF_W +: RAM_IDX_W];

    // stall length is the counter value at first sight of a request
    assign ready   = pending ? (wait_cnt == 2'd0) : (free_cnt == 2'd0);
    assign rd_rdy  = ready;
    assign wr_rdy  = ready;
    assign any_req = rd_req || wr_req;
    assign rd_fire = rd_req && rd_rdy;
    assign wr_fire = wr_req && wr_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            free_cnt <= 2'd0;
            wait_cnt <= 2'd0;
            pending  <= 1'b0;
        end else begin
            free_cnt <= free_cnt + 2'd1;
            if (rd_fire || wr_fire) begin
                pending <= 1'b0;
            end else if (any_req && !pending) begin
                pending  <= 1'b1;
                wait_cnt <= free_cnt - 2'd1;
            end else if (pending) begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RAM_LINES; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_fire) begin
            for (int b = 0; b < LINE_STRB_W; b++) begin
                if (wr_wstrb[b]) begin
                    mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    // one beat back per read, the cycle after acceptance
    always_ff @(posedge clk) begin
        if (rst) begin
            ret_valid <= 1'b0;
        end else begin
            ret_valid <= rd_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            ret_data <= mem[rd_idx];
        end
    end

    assign ret_last = ret_valid;    // no bursts

endmodule

`default_nettype wire

/* hw/dcache_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_subsys_top
    import cpu_req_pkg::*, mem_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    // CPU port
    input  logic         valid,
    input  logic         op,
    input  index_t       index,
    input  tag_t         tag,
    input  offset_t      offset,
    input  wstrb_t       wstrb,
    input  word_t        wdata,
    input  access_size_e size,
    output logic         addr_ok,
    output logic         data_ok,
    output word_t        rdata,

    // config port
    input  logic         cfg_valid,
    output logic         cfg_ready,
    input  logic         cfg_write,
    input  cfg_addr_e    cfg_addr,
    input  cfg_data_t    cfg_wdata,
    output logic         cfg_rvalid,
    output cfg_data_t    cfg_rdata
);

    logic         uncache;

    // cache to RAM bus
    logic         rd_req;
    access_size_e rd_type;
    addr_t        rd_addr;
    logic         rd_rdy;
    logic         ret_valid;
    logic         ret_last;
    line_t        ret_data;
    logic         wr_req;
    addr_t        wr_addr;
    line_strb_t   wr_wstrb;
    line_t        wr_data;
    logic         wr_rdy;

    passthru_dcache u_dcache (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .op        (op),
        .uncache   (uncache),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .size      (size),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_type   (rd_type),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_wstrb  (wr_wstrb),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    // snoops the read handshake for its counters
    uncache_window_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .tag        (tag),
        .uncache    (uncache),
        .cfg_valid  (cfg_valid),
        .cfg_ready  (cfg_ready),
        .cfg_write  (cfg_write),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rvalid (cfg_rvalid),
        .cfg_rdata  (cfg_rdata),
        .rd_req     (rd_req),
        .rd_rdy     (rd_rdy),
        .rd_type    (rd_type)
    );

    line_ram u_ram (
        .clk       (clk),
        .rst       (rst),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_wstrb  (wr_wstrb),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

endmodule

`default_nettype wire

/* testbench/tb_dcache_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_subsys
    import cpu_req_pkg::*, mem_bus_pkg::*;
();

    localparam int        WAIT_LIMIT   = 64;        // cycles per bounded wait
    localparam int        RAND_OPS     = 300;
    localparam tag_t      TAG_CACHED   = 20'h00000;
    localparam tag_t      TAG_UNCACHED = 20'h1fc00;
    localparam cfg_data_t WIN_BASE     = 32'h0001_fc00;
    localparam cfg_data_t WIN_MASK     = 32'h000f_ff00;

    logic         clk;
    logic         rst;
    logic         valid;
    logic         op;
    index_t       index;
    tag_t         tag;
    offset_t      offset;
    wstrb_t       wstrb;
    word_t        wdata;
    access_size_e size;
    logic         addr_ok;
    logic         data_ok;
    word_t        rdata;
    logic         cfg_valid;
    logic         cfg_ready;
    logic         cfg_write;
    cfg_addr_e    cfg_addr;
    cfg_data_t    cfg_wdata;
    logic         cfg_rvalid;
    cfg_data_t    cfg_rdata;

    // reference model of the RAM as words on addr[9:2]
    word_t     model_mem [256];
    cfg_data_t model_base;
    cfg_data_t model_mask;
    cfg_data_t model_fills;
    cfg_data_t model_narrows;

    logic [31:0] lfsr;
    int          ok_count;          // data_ok pulses seen
    int          access_count;      // accesses completed

    dcache_subsys_top uut (
        .clk        (clk),
        .rst        (rst),
        .valid      (valid),
        .op         (op),
        .index      (index),
        .tag        (tag),
        .offset     (offset),
        .wstrb      (wstrb),
        .wdata      (wdata),
        .size       (size),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .cfg_valid  (cfg_valid),
        .cfg_ready  (cfg_ready),
        .cfg_write  (cfg_write),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rvalid (cfg_rvalid),
        .cfg_rdata  (cfg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'hD000_0001;      // x^32 + x^31 + x^29 + x + 1
        end
        return n;
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("[FAIL] %s expected %08h actual %08h", name, expected, actual));
        end
    endtask

    function automatic logic in_window(input tag_t t);
        return (t & model_mask[TAG_W-1:0]) == (model_base[TAG_W-1:0] & model_mask[TAG_W-1:0]);
    endfunction

    // addr_ok and data_ok must move together
    always @(negedge clk) begin
        if (!rst) begin
            check_value("addr_ok equals data_ok", 32'(data_ok), 32'(addr_ok));
            if (data_ok) begin
                ok_count++;
            end
        end
    end

    task automatic cpu_access(input logic is_store, input tag_t t, input logic [5:0] line,
                              input offset_t off, input wstrb_t strb, input word_t data,
                              input access_size_e sz, output word_t result);
        int cycles;
        check_value("one data_ok per access", 32'(access_count), 32'(ok_count));
        @(posedge clk);
        valid  <= 1'b1;
        op     <= is_store;
        tag    <= t;
        index  <= {2'b00, line};
        offset <= off;
        wstrb  <= strb;
        wdata  <= data;
        size   <= sz;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!data_ok && cycles < WAIT_LIMIT);
        if (!data_ok) begin
            abort_run("CPU access never completed with data_ok");
        end
        result = rdata;
        @(posedge clk);
        valid <= 1'b0;
        access_count++;
    endtask

    task automatic access_and_compare(input logic is_store, input tag_t t,
                                      input logic [5:0] line, input offset_t off,
                                      input wstrb_t strb, input word_t data,
                                      input access_size_e sz, input string name);
        word_t      got;
        logic [7:0] w;
        w = {line, off[3:2]};
        cpu_access(is_store, t, line, off, strb, data, sz, got);
        if (is_store) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    model_mem[w][8*b +: 8] = data[8*b +: 8];
                end
            end
        end else begin
            check_value(name, model_mem[w], got);
            if (in_window(t)) begin
                model_narrows++;
            end else begin
                model_fills++;
            end
        end
    endtask

    task automatic random_access(input string name);
        logic [31:0]  r;
        logic         st;
        tag_t         t;
        logic [5:0]   line;
        offset_t      off;
        wstrb_t       strb;
        word_t        data;
        access_size_e sz;
        rand_bits(1, r);
        st = r[0];
        rand_bits(1, r);
        t = r[0] ? TAG_UNCACHED : TAG_CACHED;
        rand_bits(6, r);
        line = r[5:0];
        rand_bits(4, r);
        off = r[3:0];
        rand_bits(4, r);
        strb = r[3:0];
        rand_bits(32, r);
        data = r;
        rand_bits(2, r);
        case (r[1:0])
            2'd0:    sz = size_byte;
            2'd1:    sz = size_half;
            default: sz = size_word;
        endcase
        access_and_compare(st, t, line, off, strb, data, sz, name);
    endtask

    task automatic config_transfer(input logic wr, input cfg_addr_e a, input cfg_data_t d);
        int cycles;
        @(posedge clk);
        cfg_valid <= 1'b1;
        cfg_write <= wr;
        cfg_addr  <= a;
        cfg_wdata <= d;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!cfg_ready && cycles < WAIT_LIMIT);
        if (!cfg_ready) begin
            abort_run("config request was never accepted");
        end
        @(posedge clk);
        cfg_valid <= 1'b0;
        cfg_write <= 1'b0;
    endtask

    task automatic write_config(input cfg_addr_e a, input cfg_data_t d);
        config_transfer(1'b1, a, d);
        case (a)
            reg_win_base:   model_base    = d;
            reg_win_mask:   model_mask    = d;
            reg_fill_count: model_fills   = '0;    // write clears a counter
            default:        model_narrows = '0;
        endcase
    endtask

    task automatic compare_config(input cfg_addr_e a, input cfg_data_t expected,
                                  input string name);
        int cycles;
        config_transfer(1'b0, a, '0);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!cfg_rvalid && cycles < WAIT_LIMIT);
        if (!cfg_rvalid) begin
            abort_run("config read returned no cfg_rvalid");
        end
        check_value("cfg_rvalid one cycle after read", 32'd1, 32'(cycles));
        check_value(name, expected, cfg_rdata);
    endtask

    initial begin
        logic [31:0] r;
        logic [5:0]  s_line;
        offset_t     s_off;
        wstrb_t      s_strb;
        lfsr         = 32'd81024;
        rst          = 1'b1;
        valid        = 1'b0;
        op           = 1'b0;
        index        = '0;
        tag          = '0;
        offset       = '0;
        wstrb        = '0;
        wdata        = '0;
        size         = size_word;
        cfg_valid    = 1'b0;
        cfg_write    = 1'b0;
        cfg_addr     = reg_win_base;
        cfg_wdata    = '0;
        ok_count     = 0;
        access_count = 0;
        for (int i = 0; i < 256; i++) begin
            model_mem[i] = '0;
        end
        model_base    = '0;
        model_mask    = '0;
        model_fills   = '0;
        model_narrows = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // fresh RAM reads zero in every lane
        for (int i = 0; i < 16; i++) begin
            access_and_compare(1'b0, TAG_CACHED, 6'(i / 4), offset_t'((i % 4) * 4),
                               4'h0, '0, size_word, "unwritten word");
        end

        // distinct words per lane of one line
        for (int lane = 0; lane < 4; lane++) begin
            rand_bits(32, r);
            access_and_compare(1'b1, TAG_CACHED, 6'd10, offset_t'(lane * 4), 4'hf, r,
                               size_word, "lane store");
        end
        for (int lane = 0; lane < 4; lane++) begin
            access_and_compare(1'b0, TAG_CACHED, 6'd10, offset_t'(lane * 4), 4'h0, '0,
                               size_word, "lane select");
        end

        write_config(reg_win_base, WIN_BASE);
        write_config(reg_win_mask, WIN_MASK);
        compare_config(reg_win_base, WIN_BASE, "window base readback");
        compare_config(reg_win_mask, WIN_MASK, "window mask readback");
        compare_config(reg_fill_count, model_fills, "fills after reset");
        compare_config(reg_narrow_count, model_narrows, "narrow reads after reset");
        write_config(reg_fill_count, '0);
        write_config(reg_narrow_count, '0);
        compare_config(reg_fill_count, 32'd0, "fill count cleared");
        compare_config(reg_narrow_count, 32'd0, "narrow count cleared");

        // partial stores merge into the word in both windows
        for (int i = 0; i < 20; i++) begin
            rand_bits(6, r);
            s_line = r[5:0];
            rand_bits(4, r);
            s_off = r[3:0];
            rand_bits(4, r);
            s_strb = r[3:0];
            rand_bits(32, r);
            access_and_compare(1'b1, i[0] ? TAG_UNCACHED : TAG_CACHED, s_line, s_off,
                               s_strb, r, size_word, "strobed store");
            access_and_compare(1'b0, i[0] ? TAG_UNCACHED : TAG_CACHED, s_line, s_off,
                               4'h0, '0, size_word, "merged store readback");
        end
        compare_config(reg_fill_count, model_fills, "fill count");
        compare_config(reg_narrow_count, model_narrows, "narrow count");

        write_config(reg_fill_count, '0);
        for (int i = 0; i < 5; i++) begin
            access_and_compare(1'b0, TAG_CACHED, 6'(i), 4'h0, 4'h0, '0, size_word,
                               "cached load");
        end
        for (int i = 0; i < 3; i++) begin
            access_and_compare(1'b0, TAG_UNCACHED, 6'(i), 4'h4, 4'h0, '0, size_byte,
                               "uncached load");
        end
        compare_config(reg_fill_count, 32'd5, "fills since clear");
        compare_config(reg_narrow_count, model_narrows, "narrow count after clear");

        // mixed traffic with uneven gaps to vary RAM stalls
        for (int i = 0; i < RAND_OPS; i++) begin
            random_access("random access");
            rand_bits(2, r);
            repeat (r[1:0]) @(posedge clk);
        end
        compare_config(reg_fill_count, model_fills, "fill count after random traffic");
        compare_config(reg_narrow_count, model_narrows, "narrow count after random traffic");
        repeat (4) @(posedge clk);
        check_value("data_ok total", 32'(access_count), 32'(ok_count));

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
hw/cpu_req_pkg.sv
hw/mem_bus_pkg.sv
hw/passthru_dcache.sv
hw/uncache_window_regs.sv
hw/line_ram.sv
hw/dcache_subsys_top.sv
testbench/tb_dcache_subsys.sv

/* Makefile */
# Verilator build and run for the pass-through data cache

VERILATOR ?= verilator
TOP       ?= tb_dcache_subsys
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
